/* rtl/vit_config.svh */
// ----------------------------------------------------------
// Sizing of the K=7 rate 1/3 path metric unit
// Path metrics wrap at 2^VIT_PM_WIDTH with no normalization
// so the spread between states must stay under half that
// ----------------------------------------------------------
`ifndef VIT_CONFIG_SVH
`define VIT_CONFIG_SVH

// Trellis size
`define VIT_NUM_STATES 64
`define VIT_NUM_ACS 32

// Branch metric per 3-bit code label
`define VIT_BM_WIDTH 6
`define VIT_LABEL_WIDTH 3

// Modulo path metric
`define VIT_PM_WIDTH 11

`endif

/* rtl/vit_pkg.sv */
// ----------------------------------------------------------
// Metric and label types for the path metric unit
// Label table entry j is the label on the branch j -> 2j
// ----------------------------------------------------------
`default_nettype none

`include "vit_config.svh"

package vit_pkg;

	typedef logic [`VIT_BM_WIDTH-1:0] bm_t;
	typedef logic [`VIT_PM_WIDTH-1:0] pm_t;
	typedef logic [`VIT_LABEL_WIDTH-1:0] label_t;

	// Branch metrics indexed by code label
	typedef bm_t [(1 << `VIT_LABEL_WIDTH)-1:0] bm_set_t;

	typedef pm_t [`VIT_NUM_STATES-1:0] state_metrics_t;
	typedef pm_t [`VIT_NUM_ACS-1:0] acs_metrics_t;

	// Other branches of a butterfly carry the complement
	localparam label_t BUTTERFLY_LABEL [`VIT_NUM_ACS] = '{
		3'b000, 3'b110, 3'b111, 3'b001, 3'b101, 3'b011, 3'b010, 3'b100,
		3'b010, 3'b100, 3'b101, 3'b011, 3'b111, 3'b001, 3'b000, 3'b110,
		3'b001, 3'b111, 3'b110, 3'b000, 3'b100, 3'b010, 3'b011, 3'b101,
		3'b011, 3'b101, 3'b100, 3'b010, 3'b110, 3'b000, 3'b001, 3'b111
	};

endpackage

`default_nettype wire

/* rtl/acs_unit.sv */
// ----------------------------------------------------------
// Add-compare-select for one half of a butterfly
// Phase 0 gives new state 2j, phase 1 gives new state 2j+1
// A tie keeps the upper (state j) path
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module acs_unit import vit_pkg::*; (
	input  logic phase,
	input  pm_t  pm_upper,
	input  pm_t  pm_lower,
	input  bm_t  bm_direct,
	input  bm_t  bm_cross,
	output pm_t  pm_out,
	output logic decision
);

	pm_t bm_upper_ext;
	pm_t bm_lower_ext;
	pm_t cand_upper;
	pm_t cand_lower;
	pm_t cand_diff;

	// Odd new state sees the labels swapped
	assign bm_upper_ext = pm_t'(phase ? bm_cross : bm_direct);
	assign bm_lower_ext = pm_t'(phase ? bm_direct : bm_cross);

	assign cand_upper = pm_upper + bm_upper_ext;
	assign cand_lower = pm_lower + bm_lower_ext;

	// Modulo compare by sign of the difference
	assign cand_diff = cand_lower - cand_upper;
	assign decision = cand_diff[`VIT_PM_WIDTH-1];

	assign pm_out = decision ? cand_lower : cand_upper;

endmodule

`default_nettype wire

/* rtl/acs_bank.sv */
// ----------------------------------------------------------
// 32 ACS butterflies, time-shared over the two phases
// Butterfly j reads old states j and j+32
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module acs_bank import vit_pkg::*; (
	input  logic                    phase,
	input  bm_set_t                 bm_set,
	input  state_metrics_t          old_metrics,
	output acs_metrics_t            new_metrics,
	output logic [`VIT_NUM_ACS-1:0] decisions
);

	genvar j;

	generate
		for (j = 0; j < `VIT_NUM_ACS; j++) begin : g_bfly
			localparam label_t LBL_DIRECT = BUTTERFLY_LABEL[j];
			localparam label_t LBL_CROSS = ~BUTTERFLY_LABEL[j];

			bm_t bm_direct;
			bm_t bm_cross;

			// Fixed routing from the label table
			assign bm_direct = bm_set[LBL_DIRECT];
			assign bm_cross = bm_set[LBL_CROSS];

			acs_unit u_acs (
				.phase     (phase),
				.pm_upper  (old_metrics[j]),
				.pm_lower  (old_metrics[j + `VIT_NUM_ACS]),
				.bm_direct (bm_direct),
				.bm_cross  (bm_cross),
				.pm_out    (new_metrics[j]),
				.decision  (decisions[j])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* rtl/path_metric_store.sv */
// ----------------------------------------------------------
// Phase toggle and the 64 path metric registers
// Even-state results wait in staging for one clock; all 64
// metrics change together on the edge that ends phase B
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module path_metric_store import vit_pkg::*; (
	input  logic           clk,
	input  logic           reset_n,
	input  acs_metrics_t   new_metrics,
	output logic           phase,
	output state_metrics_t old_metrics
);

	acs_metrics_t   pm_stage;
	state_metrics_t pm_reg;

	// ----------------------------------------------------------
	// Phase, 0 = phase A (even states), 1 = phase B (odd states)
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			phase <= 1'b0;
		end else begin
			phase <= ~phase;
		end
	end

	// ----------------------------------------------------------
	// Phase A staging
	// ----------------------------------------------------------
	// Holds survivors of new states 2j until phase B ends
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pm_stage <= '0;
		end else if (!phase) begin
			pm_stage <= new_metrics;
		end
	end

	// ----------------------------------------------------------
	// Write-back in new-state order
	// ----------------------------------------------------------
	// Old metrics stay put through phase A so both phases
	// see the same previous step
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pm_reg <= '0;
		end else if (phase) begin
			for (int j = 0; j < `VIT_NUM_ACS; j++) begin
				// Even from staging
				pm_reg[2*j] <= pm_stage[j];
				// Odd straight from the ACS
				pm_reg[2*j + 1] <= new_metrics[j];
			end
		end
	end

	assign old_metrics = pm_reg;

endmodule

`default_nettype wire

/* rtl/decision_register.sv */
// ----------------------------------------------------------
// Survivor decision word of one trellis step
// sel_out loads on the edge that ends phase B and holds
// for two clocks; bit n is the decision for new state n
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module decision_register import vit_pkg::*; (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       phase,
	input  logic [`VIT_NUM_ACS-1:0]    decisions,
	output logic [`VIT_NUM_STATES-1:0] sel_out
);

	logic [`VIT_NUM_ACS-1:0] dec_stage;

	// Phase A decisions, for the even states
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			dec_stage <= '0;
		end else if (!phase) begin
			dec_stage <= decisions;
		end
	end

	// Interleave staged even bits with live odd bits
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sel_out <= '0;
		end else if (phase) begin
			for (int j = 0; j < `VIT_NUM_ACS; j++) begin
				sel_out[2*j] <= dec_stage[j];
				sel_out[2*j + 1] <= decisions[j];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/viterbi_pmu.sv */
// ----------------------------------------------------------
// Path metric unit, one trellis step every two clocks
// Branch metrics must be held for a phase A and a phase B
// cycle; phase A is the cycle with clk_div2_out high
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module viterbi_pmu import vit_pkg::*; (
	input  logic                       clk,
	input  logic                       reset_n,
	input  bm_t                        bm_000,
	input  bm_t                        bm_001,
	input  bm_t                        bm_010,
	input  bm_t                        bm_011,
	input  bm_t                        bm_100,
	input  bm_t                        bm_101,
	input  bm_t                        bm_110,
	input  bm_t                        bm_111,
	output logic [`VIT_NUM_STATES-1:0] sel_out,
	output logic                       clk_div2_out
);

	bm_set_t                 bm_set;
	logic                    phase;
	state_metrics_t          old_metrics;
	acs_metrics_t            new_metrics;
	logic [`VIT_NUM_ACS-1:0] decisions;

	// Pack by code label
	assign bm_set = {bm_111, bm_110, bm_101, bm_100, bm_011, bm_010, bm_001, bm_000};

	assign clk_div2_out = ~phase;

	acs_bank u_acs_bank (
		.phase       (phase),
		.bm_set      (bm_set),
		.old_metrics (old_metrics),
		.new_metrics (new_metrics),
		.decisions   (decisions)
	);

	path_metric_store u_path_metric_store (
		.clk         (clk),
		.reset_n     (reset_n),
		.new_metrics (new_metrics),
		.phase       (phase),
		.old_metrics (old_metrics)
	);

	decision_register u_decision_register (
		.clk       (clk),
		.reset_n   (reset_n),
		.phase     (phase),
		.decisions (decisions),
		.sel_out   (sel_out)
	);

endmodule

`default_nettype wire

/* verif/viterbi_pmu_sva.sv */
// ----------------------------------------------------------
// Phase and decision timing checks for the path metric unit
// Bound into decision_register where phase is an input
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module viterbi_pmu_sva import vit_pkg::*; (
	input logic                       clk,
	input logic                       reset_n,
	input logic                       phase,
	input logic [`VIT_NUM_STATES-1:0] sel_out
);

	// Phase alternates on every clock out of reset
	phase_toggles: assert property (@(posedge clk) disable iff (!reset_n)
		1'b1 |=> (phase != $past(phase)))
		else $error("phase did not toggle on a clock edge");

	// New decision word only on the edge that ends phase B
	sel_after_phase_b: assert property (@(posedge clk) disable iff (!reset_n)
		(sel_out != $past(sel_out)) |-> $past(phase))
		else $error("sel_out changed after a phase A cycle");

	// Reset holds phase A and a cleared decision word
	reset_state: assert property (@(posedge clk)
		!reset_n |=> (!phase && sel_out == '0))
		else $error("phase or sel_out not cleared by reset");

endmodule

`default_nettype wire

/* verif/viterbi_pmu_tb.sv */
// ----------------------------------------------------------
// Testbench for the path metric unit, table driven
// Random branch metrics are 5 bits so the metric spread
// stays well inside the modulo compare range
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "vit_config.svh"

module viterbi_pmu_tb import vit_pkg::*;;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS = 44;
	localparam int ZERO_ROWS = 4;
	localparam int NUM_LABELS = 1 << `VIT_LABEL_WIDTH;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_ROWS + 40;

	logic clk = 1'b0;
	logic reset_n;
	bm_t bm_000;
	bm_t bm_001;
	bm_t bm_010;
	bm_t bm_011;
	bm_t bm_100;
	bm_t bm_101;
	bm_t bm_110;
	bm_t bm_111;
	logic [`VIT_NUM_STATES-1:0] sel_out;
	logic clk_div2_out;

	// Stimulus and expected decision words, one row per trellis step
	bm_t bm_tab [NUM_ROWS][NUM_LABELS];
	logic [`VIT_NUM_STATES-1:0] exp_sel [NUM_ROWS];

	pm_t model_pm [`VIT_NUM_STATES];
	logic [15:0] lfsr_state;
	int cycle_count = 0;

	viterbi_pmu DUT (
		.clk          (clk),
		.reset_n      (reset_n),
		.bm_000       (bm_000),
		.bm_001       (bm_001),
		.bm_010       (bm_010),
		.bm_011       (bm_011),
		.bm_100       (bm_100),
		.bm_101       (bm_101),
		.bm_110       (bm_110),
		.bm_111       (bm_111),
		.sel_out      (sel_out),
		.clk_div2_out (clk_div2_out)
	);

	bind decision_register viterbi_pmu_sva u_sva (
		.clk     (clk),
		.reset_n (reset_n),
		.phase   (phase),
		.sel_out (sel_out)
	);

	always #(CLK_HALF) clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	// ----------------------------------------------------------
	// Stimulus generation and reference model
	// ----------------------------------------------------------
	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			lfsr_next = (s >> 1) ^ 16'hB400;
		else
			lfsr_next = s >> 1;
	endfunction

	// One step per bit, five bits per metric
	task automatic draw_metric(output bm_t value);
		logic [4:0] bits;
		bits = '0;
		for (int b = 0; b < 5; b++) begin
			bits = {bits[3:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		value = {1'b0, bits};
	endtask

	task automatic build_table();
		bm_t metric;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int l = 0; l < NUM_LABELS; l++) begin
				if (r < ZERO_ROWS)
					metric = '0;
				else
					draw_metric(metric);
				bm_tab[r][l] = metric;
			end
		end
	endtask

	// True when a is below b on the modulo metric circle
	function automatic logic mod_less(input pm_t a, input pm_t b);
		pm_t d;
		d = a - b;
		mod_less = d[`VIT_PM_WIDTH-1];
	endfunction

	// New state s has predecessors s/2 and s/2+32
	task automatic model_step(input int row, output logic [`VIT_NUM_STATES-1:0] word);
		pm_t next_pm [`VIT_NUM_STATES];
		label_t lbl;
		bm_t bm_up;
		bm_t bm_lo;
		pm_t cand_up;
		pm_t cand_lo;
		int j;
		word = '0;
		for (int s = 0; s < `VIT_NUM_STATES; s++) begin
			j = s / 2;
			lbl = BUTTERFLY_LABEL[j];
			// Even target takes the label from the upper state
			if (s % 2 == 0) begin
				bm_up = bm_tab[row][lbl];
				bm_lo = bm_tab[row][~lbl];
			end else begin
				bm_up = bm_tab[row][~lbl];
				bm_lo = bm_tab[row][lbl];
			end
			cand_up = model_pm[j] + pm_t'(bm_up);
			cand_lo = model_pm[j + `VIT_NUM_ACS] + pm_t'(bm_lo);
			word[s] = mod_less(cand_lo, cand_up);
			next_pm[s] = word[s] ? cand_lo : cand_up;
		end
		model_pm = next_pm;
	endtask

	task automatic compute_expected();
		for (int s = 0; s < `VIT_NUM_STATES; s++)
			model_pm[s] = '0;
		for (int r = 0; r < NUM_ROWS; r++)
			model_step(r, exp_sel[r]);
	endtask

	// ----------------------------------------------------------
	// Driving and checking
	// ----------------------------------------------------------
	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, actual, expected);
			$display("Checks failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic drive_row(input int r);
		bm_000 = bm_tab[r][0];
		bm_001 = bm_tab[r][1];
		bm_010 = bm_tab[r][2];
		bm_011 = bm_tab[r][3];
		bm_100 = bm_tab[r][4];
		bm_101 = bm_tab[r][5];
		bm_110 = bm_tab[r][6];
		bm_111 = bm_tab[r][7];
	endtask

	task automatic wait_phase_a();
		while (clk_div2_out !== 1'b1)
			@(negedge clk);
	endtask

	// prev is the word that must still show during phase A
	task automatic run_step(input int r, input logic [63:0] prev);
		wait_phase_a();
		drive_row(r);
		@(negedge clk);
		check_value("clk_div2_out", 64'(clk_div2_out), 64'd0);
		check_value("sel_out", sel_out, prev);
		@(negedge clk);
		check_value("clk_div2_out", 64'(clk_div2_out), 64'd1);
		check_value("sel_out", sel_out, exp_sel[r]);
	endtask

	initial begin
		reset_n = 1'b0;
		lfsr_state = 16'd93;
		build_table();
		compute_expected();
		drive_row(0);

		repeat (RESET_CYCLES) @(negedge clk);
		reset_n = 1'b1;
		check_value("sel_out", sel_out, 64'd0);
		check_value("clk_div2_out", 64'(clk_div2_out), 64'd1);

		run_step(0, 64'd0);
		for (int r = 1; r < NUM_ROWS; r++)
			run_step(r, exp_sel[r - 1]);

		// Reset in phase B with nonzero metrics in the store
		wait_phase_a();
		drive_row(NUM_ROWS - 1);
		@(negedge clk);
		reset_n = 1'b0;
		#(CLK_HALF / 2);
		check_value("sel_out", sel_out, 64'd0);
		check_value("clk_div2_out", 64'(clk_div2_out), 64'd1);
		repeat (2) @(negedge clk);
		reset_n = 1'b1;
		check_value("clk_div2_out", 64'(clk_div2_out), 64'd1);

		// Model from zero metrics gives the same first rows
		run_step(0, 64'd0);
		for (int r = 1; r < ZERO_ROWS; r++)
			run_step(r, exp_sel[r - 1]);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* viterbi_pmu.f */
+incdir+rtl
rtl/vit_pkg.sv
rtl/acs_unit.sv
rtl/acs_bank.sv
rtl/path_metric_store.sv
rtl/decision_register.sv
rtl/viterbi_pmu.sv
verif/viterbi_pmu_sva.sv
verif/viterbi_pmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the path metric unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module viterbi_pmu_tb \
	-f viterbi_pmu.f

./obj_dir/Vviterbi_pmu_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
	echo "Simulation FAILED, run ended without a result"
	exit 1
fi

echo "Simulation PASSED"
